/* compile.f */
+incdir+include
verilog/graph_pkg.sv
verilog/display_timing.sv
verilog/plot_coords.sv
verilog/func_squared.sv
verilog/pixel_colour.sv
verilog/graph_top.sv
verification/graph_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the graph demo with Verilator and run the self-checking testbench.
# A $fatal in the testbench gives a non-zero exit status, so set -e stops here.
set -e

cd "$(dirname "$0")"

verilator --binary --assert -j 0 \
    --top-module graph_tb \
    -f compile.f \
    -o graph_sim

./obj_dir/graph_sim

/* verification/graph_testdata.txt */
// Probe pixels, one per line: column row colour (hex)
// Colour is 12-bit RGB, 000 blank, 222 background, CCC axis, 3BC curve
0000 0000 222
027F 0000 222
0140 00F0 CCC
0140 0000 CCC
0000 00F0 CCC
027F 00F0 CCC
0140 01DF CCC
0148 00EF 3BC
0148 00EE 3BC
0148 00ED 222
0138 00EF 3BC
0180 00B0 3BC
0100 00B0 3BC
0180 00B1 222
01BC 0000 3BC
01BD 0000 222
0280 0000 000
031F 020C 000

/* verification/graph_tb.sv */
// Graph demo testbench
// Own raster model checks sync, blanking, axes, curve and probe pixels over a frame
`include "graph_consts.svh"

module graph_tb
    import graph_pkg::*;
();

    localparam int FRAME_CYCLES   = `H_TOTAL * `V_TOTAL;
    localparam int TIMEOUT_CYCLES = 2 * FRAME_CYCLES + 100;  // Two frames plus slack
    localparam int PIPE_LAT       = 5;                        // Raster to pins
    localparam int PROBE_MAX      = 32;
    localparam video_out_t IDLE_VIDEO = '{hsync: 1'b1, vsync: 1'b1, de: 1'b0,
                                          r: '0, g: '0, b: '0};

    logic       clk_pix = 1'b0;
    logic       rst_n;
    video_out_t video;
    logic       frame_start;

    logic [15:0] probe_mem [0:3*PROBE_MAX-1];   // Column, row, colour per probe
    logic        probe_hit [PROBE_MAX];
    int          probe_cnt;
    int          cycle_cnt = 0;
    int          first_frame_cycle;

    graph_top u_graph_top (
        .clk_pix     (clk_pix),
        .rst_n       (rst_n),
        .video       (video),
        .frame_start (frame_start)
    );

    always #20 clk_pix = ~clk_pix;   // 40 unit period

    // Run limit
    always @(posedge clk_pix) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            abort_run("Timed out waiting for two frame_start pulses");
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1, "run stopped");
    endtask

    // Reference raster rules
    function automatic logic model_de(input int col, input int row);
        return (col < `H_RES) && (row < `V_RES);
    endfunction

    function automatic logic model_hsync(input int col);
        return !((col >= `H_RES + `H_FP) && (col < `H_RES + `H_FP + `H_SYNC));
    endfunction

    function automatic logic model_vsync(input int row);
        return !((row >= `V_RES + `V_FP) && (row < `V_RES + `V_FP + `V_SYNC));
    endfunction

    // Palette by priority, curve from the centred coordinates
    function automatic logic [11:0] model_rgb(input int col, input int row);
        int x;
        int y;
        int d;
        x = col - `X_OFFS;
        y = `Y_OFFS - row;               // Up is positive
        d = y - ((x * x) >> `FUNC_SHIFT);
        if (!model_de(col, row)) begin
            return `COL_BLANK;
        end else if ((row == `Y_OFFS) || (col == `X_OFFS)) begin
            return `COL_AXIS;
        end else if ((d >= 0) && (d < `LINE_W)) begin
            return `COL_CURVE;
        end else begin
            return `COL_BG;
        end
    endfunction

    function automatic video_out_t model_video(input int col, input int row);
        video_out_t  v;
        logic [11:0] rgb;
        rgb     = model_rgb(col, row);
        v.hsync = model_hsync(col);
        v.vsync = model_vsync(row);
        v.de    = model_de(col, row);
        v.r     = rgb[11:8];
        v.g     = rgb[7:4];
        v.b     = rgb[3:0];
        return v;
    endfunction

    task automatic check_sync(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_colour(input colour_t r, input colour_t g, input colour_t b,
                                input colour_t er, input colour_t eg, input colour_t eb,
                                input string what);
        if ({r, g, b} !== {er, eg, eb}) begin
            abort_run($sformatf("[FAIL] %0t: %s colour %h%h%h, expected %h%h%h",
                                $time, what, r, g, b, er, eg, eb));
        end
    endtask

    task automatic check_video(input video_out_t got, input video_out_t exp,
                               input string what);
        check_sync(got.hsync, exp.hsync, {what, " hsync"});
        check_sync(got.vsync, exp.vsync, {what, " vsync"});
        check_sync(got.de, exp.de, {what, " de"});
        check_colour(got.r, got.g, got.b, exp.r, exp.g, exp.b, what);
    endtask

    task automatic check_period(input int got);
        if (got != FRAME_CYCLES) begin
            abort_run($sformatf("[FAIL] %0t: frame period %0d cycles, expected %0d",
                                $time, got, FRAME_CYCLES));
        end
    endtask

    // Second opinion from the probe file
    task automatic check_probes(input int col, input int row);
        for (int i = 0; i < probe_cnt; i++) begin
            if ((probe_mem[3*i] == 16'(col)) && (probe_mem[3*i+1] == 16'(row))) begin
                check_colour(video.r, video.g, video.b,
                             colour_t'(probe_mem[3*i+2][11:8]),
                             colour_t'(probe_mem[3*i+2][7:4]),
                             colour_t'(probe_mem[3*i+2][3:0]),
                             $sformatf("probe %0d at (%0d,%0d)", i, col, row));
                probe_hit[i] = 1'b1;
            end
        end
    endtask

    task automatic check_pixel(input int col, input int row);
        check_video(video, model_video(col, row), $sformatf("pixel (%0d,%0d)", col, row));
        check_sync(frame_start, (col == 0) && (row == 0), "frame_start");
        check_probes(col, row);
    endtask

    initial begin
        int first_missed;
        rst_n = 1'b0;
        for (int i = 0; i < 3 * PROBE_MAX; i++) begin
            probe_mem[i] = 16'hFFFF;             // End marker for unused slots
        end
        for (int i = 0; i < PROBE_MAX; i++) begin
            probe_hit[i] = 1'b0;
        end
        $readmemh("verification/graph_testdata.txt", probe_mem);
        probe_cnt = 0;
        while ((probe_cnt < PROBE_MAX) && (probe_mem[3*probe_cnt] != 16'hFFFF)) begin
            probe_cnt++;
        end
        if (probe_cnt == 0) begin
            abort_run("No probe pixels could be loaded from the testdata file");
        end

        // Reset over three rising edges, pins idle
        repeat (2) begin
            @(negedge clk_pix);
            check_video(video, IDLE_VIDEO, "reset");
            check_sync(frame_start, 1'b0, "reset frame_start");
        end
        @(posedge clk_pix);
        rst_n <= 1'b1;

        // Cleared pipeline drains first
        repeat (PIPE_LAT) begin
            @(negedge clk_pix);
            check_video(video, IDLE_VIDEO, "pipeline fill");
            check_sync(frame_start, 1'b0, "pipeline fill frame_start");
        end

        // First frame after reset is partial
        @(negedge clk_pix);
        while (!frame_start) begin
            @(negedge clk_pix);
        end
        first_frame_cycle = cycle_cnt;

        // One full frame against the model
        for (int row = 0; row < `V_TOTAL; row++) begin
            for (int col = 0; col < `H_TOTAL; col++) begin
                if ((col != 0) || (row != 0)) begin
                    @(negedge clk_pix);
                end
                check_pixel(col, row);
            end
        end

        // Next frame pulse, counted from the first
        @(negedge clk_pix);
        while (!frame_start) begin
            @(negedge clk_pix);
        end
        check_period(cycle_cnt - first_frame_cycle);
        check_video(video, model_video(0, 0), "pixel (0,0) of second frame");

        first_missed = -1;
        for (int i = 0; i < probe_cnt; i++) begin
            if (!probe_hit[i] && (first_missed < 0)) begin
                first_missed = i;
            end
        end
        if (first_missed < 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            abort_run($sformatf("Probe %0d was never reached during the frame", first_missed));
        end
    end

endmodule

/* verilog/graph_top.sv */
// Graph demo top level
// Timing, coordinates, curve evaluation and colour output in one pixel clock domain
module graph_top
    import graph_pkg::*;
(
    input  logic       clk_pix,
    input  logic       rst_n,
    output video_out_t video,
    output logic       frame_start
);

    raster_t raster;     // Raster position and controls
    plot_t   plot;       // Centred coordinates, one cycle behind
    logic    on_curve;   // FUNC_LAT cycles behind plot

    // Counters and sync windows
    display_timing u_display_timing (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .raster  (raster)
    );

    // Origin shift and axis flags
    plot_coords u_plot_coords (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .raster  (raster),
        .plot    (plot)
    );

    // Curve test on the centred coordinates
    func_squared u_func_squared (
        .clk_pix  (clk_pix),
        .rst_n    (rst_n),
        .x        (plot.x),
        .y        (plot.y),
        .on_curve (on_curve)
    );

    // Alignment, palette and output registers
    pixel_colour u_pixel_colour (
        .clk_pix     (clk_pix),
        .rst_n       (rst_n),
        .plot        (plot),
        .frame       (raster.frame),   // Delayed one extra stage inside
        .on_curve    (on_curve),
        .video       (video),
        .frame_start (frame_start)
    );

endmodule

/* verilog/pixel_colour.sv */
// Pixel colour stage
// Aligns video controls with the curve result, applies the palette, registers the pins
`include "graph_consts.svh"

module pixel_colour
    import graph_pkg::*;
(
    input  logic       clk_pix,
    input  logic       rst_n,
    input  plot_t      plot,
    input  logic       frame,
    input  logic       on_curve,
    output video_out_t video,
    output logic       frame_start
);

    localparam plot_t PLOT_IDLE = '{x: '0, y: '0, axes: 1'b0,
                                    hsync: 1'b1, vsync: 1'b1, de: 1'b0};

    plot_t             plot_dly [`FUNC_LAT];   // Matches func_squared latency
    logic [`FUNC_LAT:0] frame_dly;             // Frame comes straight from the raster
    plot_t             cur;                    // Entry meeting on_curve
    logic [11:0]       rgb;

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `FUNC_LAT; i++) begin
                plot_dly[i] <= PLOT_IDLE;
            end
            frame_dly <= '0;
        end else begin
            plot_dly[0] <= plot;
            for (int i = 1; i < `FUNC_LAT; i++) begin
                plot_dly[i] <= plot_dly[i-1];
            end
            frame_dly <= {frame_dly[`FUNC_LAT-1:0], frame};  // One extra, no plot stage
        end
    end

    // Palette by priority
    always_comb begin
        cur = plot_dly[`FUNC_LAT-1];
        if (!cur.de) begin
            rgb = `COL_BLANK;
        end else if (cur.axes) begin
            rgb = `COL_AXIS;             // Axes drawn over the curve
        end else if (on_curve) begin
            rgb = `COL_CURVE;
        end else begin
            rgb = `COL_BG;
        end
    end

    // Output registers, stand-in for I/O pad flops
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            video       <= '{hsync: 1'b1, vsync: 1'b1, de: 1'b0,
                             r: '0, g: '0, b: '0};
            frame_start <= 1'b0;
        end else begin
            video       <= '{hsync: cur.hsync, vsync: cur.vsync, de: cur.de,
                             r: rgb[11:8], g: rgb[7:4], b: rgb[3:0]};
            frame_start <= frame_dly[`FUNC_LAT];
        end
    end

    // Blanked pixel stays black at the pins
    a_blank: assert property (
        @(posedge clk_pix) disable iff (!rst_n)
        !cur.de |=> ({video.r, video.g, video.b} == `COL_BLANK)
    ) else $error("colour during blanking");

endmodule

/* verilog/func_squared.sv */
// Curve evaluator for y = x*x / 64
// Three register stages, one new pixel accepted every clock
`include "graph_consts.svh"

module func_squared
    import graph_pkg::*;
(
    input  logic        clk_pix,
    input  logic        rst_n,
    input  plot_coord_t x,
    input  plot_coord_t y,
    output logic        on_curve
);

    typedef logic signed [22:0] diff_t;   // Room for y minus a 16-bit term

    localparam diff_t LINE_WIDTH = diff_t'(`LINE_W);   // Upper bound of the window

    logic signed [21:0] prod;   // Full square, fits in 17 bits for |x| <= 320
    square_t            sq_s1;
    plot_coord_t        y_s1;
    diff_t              diff_s2;

    always_comb begin
        prod = x * x;
    end

    // Stage 1 square, y kept alongside
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            sq_s1 <= '0;
            y_s1  <= '0;
        end else begin
            sq_s1 <= square_t'(prod);
            y_s1  <= y;
        end
    end

    // Stage 2 scale and subtract
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            diff_s2 <= '0;
        end else begin
            diff_s2 <= diff_t'(y_s1) - diff_t'({1'b0, sq_s1 >> `FUNC_SHIFT});
        end
    end

    // Stage 3 thickness window [0, LINE_W)
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            on_curve <= 1'b0;
        end else begin
            on_curve <= !diff_s2[22] && (diff_s2 < LINE_WIDTH);
        end
    end

    // Square treated as signed downstream, top bit must stay clear
    a_sq_positive: assert property (
        @(posedge clk_pix) disable iff (!rst_n)
        !sq_s1[$bits(square_t)-1]
    ) else $error("stage 1 square negative when sign extended");

    // Vertex sits on the curve FUNC_LAT cycles later
    a_vertex: assert property (
        @(posedge clk_pix) disable iff (!rst_n)
        (x == '0) && (y == '0) |-> ##`FUNC_LAT on_curve
    ) else $error("vertex missed");

endmodule

/* verilog/plot_coords.sv */
// Graph coordinate stage
// Centres the raster on the origin and flags the axes, one register deep
`include "graph_consts.svh"

module plot_coords
    import graph_pkg::*;
(
    input  logic    clk_pix,
    input  logic    rst_n,
    input  raster_t raster,
    output plot_t   plot
);

    localparam plot_coord_t X_ORG    = plot_coord_t'(`X_OFFS);
    localparam plot_coord_t Y_ORG    = plot_coord_t'(`Y_OFFS);
    localparam scr_coord_t  AXIS_COL = scr_coord_t'(`X_OFFS);  // Vertical axis
    localparam scr_coord_t  AXIS_ROW = scr_coord_t'(`Y_OFFS);  // Horizontal axis

    plot_coord_t sx_wide;   // Raster position zero-extended
    plot_coord_t sy_wide;
    logic        on_axes;

    always_comb begin
        sx_wide = plot_coord_t'({2'b00, raster.sx});
        sy_wide = plot_coord_t'({2'b00, raster.sy});
        on_axes = (raster.sy == AXIS_ROW) || (raster.sx == AXIS_COL);
    end

    // x grows right, y grows up
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            plot.x     <= '0;
            plot.y     <= '0;
            plot.axes  <= 1'b0;
            plot.hsync <= 1'b1;
            plot.vsync <= 1'b1;
            plot.de    <= 1'b0;
        end else begin
            plot.x     <= sx_wide - X_ORG;
            plot.y     <= Y_ORG - sy_wide;
            plot.axes  <= on_axes;
            plot.hsync <= raster.hsync;   // Controls keep pace with x and y
            plot.vsync <= raster.vsync;
            plot.de    <= raster.de;
        end
    end

    // Centre of the screen maps to the origin one cycle later
    a_origin: assert property (
        @(posedge clk_pix) disable iff (!rst_n)
        (raster.sx == AXIS_COL) && (raster.sy == AXIS_ROW)
        |=> (plot.x == '0) && (plot.y == '0) && plot.axes
    ) else $error("origin not at screen centre");

endmodule

/* verilog/display_timing.sv */
// Display timing generator for 640x480
// Free-running raster counters with registered sync, data enable and frame pulse
`include "graph_consts.svh"

module display_timing
    import graph_pkg::*;
(
    input  logic    clk_pix,
    input  logic    rst_n,
    output raster_t raster
);

    // Window edges as raster positions
    localparam scr_coord_t H_LAST   = scr_coord_t'(`H_TOTAL - 1);
    localparam scr_coord_t V_LAST   = scr_coord_t'(`V_TOTAL - 1);
    localparam scr_coord_t HS_START = scr_coord_t'(`H_RES + `H_FP);
    localparam scr_coord_t HS_END   = scr_coord_t'(`H_RES + `H_FP + `H_SYNC);
    localparam scr_coord_t VS_START = scr_coord_t'(`V_RES + `V_FP);
    localparam scr_coord_t VS_END   = scr_coord_t'(`V_RES + `V_FP + `V_SYNC);
    localparam scr_coord_t H_ACT    = scr_coord_t'(`H_RES);
    localparam scr_coord_t V_ACT    = scr_coord_t'(`V_RES);

    scr_coord_t sx_next;   // Position for the coming cycle
    scr_coord_t sy_next;
    logic       hs_next;
    logic       vs_next;
    logic       de_next;
    logic       frame_next;

    // Step the position, wrap at the end of line and frame
    always_comb begin
        sx_next = raster.sx + 1'b1;
        sy_next = raster.sy;
        if (raster.sx == H_LAST) begin
            sx_next = '0;
            if (raster.sy == V_LAST) begin
                sy_next = '0;         // New frame
            end else begin
                sy_next = raster.sy + 1'b1;
            end
        end
    end

    // Flags decoded from the next position so they register with it
    always_comb begin
        hs_next    = !((sx_next >= HS_START) && (sx_next < HS_END));  // Low in pulse
        vs_next    = !((sy_next >= VS_START) && (sy_next < VS_END));
        de_next    = (sx_next < H_ACT) && (sy_next < V_ACT);
        frame_next = (sx_next == '0) && (sy_next == '0);
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            raster.sx    <= '0;
            raster.sy    <= '0;
            raster.hsync <= 1'b1;     // Syncs idle high
            raster.vsync <= 1'b1;
            raster.de    <= 1'b0;
            raster.frame <= 1'b0;
        end else begin
            raster.sx    <= sx_next;
            raster.sy    <= sy_next;
            raster.hsync <= hs_next;
            raster.vsync <= vs_next;
            raster.de    <= de_next;
            raster.frame <= frame_next;
        end
    end

    // Column counter never leaves the line
    a_sx_range: assert property (
        @(posedge clk_pix) disable iff (!rst_n)
        raster.sx <= H_LAST
    ) else $error("sx out of range");

    // Frame pulse only on the first visible pixel
    a_frame_de: assert property (
        @(posedge clk_pix) disable iff (!rst_n)
        raster.frame |-> raster.de
    ) else $error("frame pulse outside active area");

endmodule

/* verilog/graph_pkg.sv */
// Graph demo types
// Shared coordinate, colour and pipeline structs
package graph_pkg;

    typedef logic        [9:0]  scr_coord_t;   // Raster position
    typedef logic signed [11:0] plot_coord_t;  // Centred graph coordinate
    typedef logic        [21:0] square_t;      // x*x, always positive
    typedef logic        [3:0]  colour_t;      // One colour channel

    // Output of the timing generator
    typedef struct packed {
        scr_coord_t sx;
        scr_coord_t sy;
        logic       hsync;   // Active low
        logic       vsync;   // Active low
        logic       de;
        logic       frame;   // One cycle at (0,0)
    } raster_t;

    // Graph coordinates plus the video controls riding alongside
    typedef struct packed {
        plot_coord_t x;
        plot_coord_t y;
        logic        axes;   // On either axis
        logic        hsync;
        logic        vsync;
        logic        de;
    } plot_t;

    // Registered pins
    typedef struct packed {
        logic    hsync;
        logic    vsync;
        logic    de;
        colour_t r;
        colour_t g;
        colour_t b;
    } video_out_t;

endpackage

/* include/graph_consts.svh */
// Graph demo constants
// 640x480 display timing, graph origin, curve shape and palette
`ifndef GRAPH_CONSTS_SVH
`define GRAPH_CONSTS_SVH

// Horizontal timing in pixels
`define H_RES      640
`define H_FP       16
`define H_SYNC     96
`define H_TOTAL    800

// Vertical timing in lines
`define V_RES      480
`define V_FP       10
`define V_SYNC     2
`define V_TOTAL    525

// Origin of the graph on screen
`define X_OFFS     320
`define Y_OFFS     240

// Curve y = x*x >> FUNC_SHIFT, drawn LINE_W units thick
`define FUNC_SHIFT 6
`define LINE_W     2
`define FUNC_LAT   3            // Pipeline depth of func_squared

// 12-bit RGB palette
`define COL_BLANK  12'h000
`define COL_BG     12'h222
`define COL_AXIS   12'hCCC
`define COL_CURVE  12'h3BC

`endif
